//--- rtl/sa_pkg.sv
// Self-attention shared definitions
`default_nettype none

package sa_pkg;

	localparam int DIM = 8;
	localparam int IDX_W = 3;
	// One phase walks the whole DIM x DIM grid
	localparam int STEP_CYCLES = 64;
	localparam int FLUSH_CYCLES = 2;

	typedef logic signed [7:0] feat_t;
	typedef logic signed [18:0] proj_t;
	typedef logic signed [40:0] score_t;
	typedef logic signed [59:0] prod_t;
	typedef logic signed [63:0] result_t;

	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [3:0] tcount_t;
	typedef logic [5:0] emit_t;

	typedef enum logic [2:0] {
		IDLE,
		GATHER,
		PROJ_Q,
		PROJ_K,
		PROJ_VS,
		FLUSH,
		EMIT
	} sa_phase_t;

endpackage

`default_nettype wire

//--- rtl/sa_phase_fsm.sv
// Attention job phase sequencer
`default_nettype none

module sa_phase_fsm
	import sa_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic wrap,
	input logic flush_done,
	input logic emit_done,
	output sa_phase_t phase
);

	sa_phase_t next_phase;

	always_comb begin
		next_phase = phase;
		case (phase)
			IDLE: if (in_valid) next_phase = GATHER;
			GATHER: if (wrap) next_phase = PROJ_Q;
			PROJ_Q: if (wrap) next_phase = PROJ_K;
			PROJ_K: if (wrap) next_phase = PROJ_VS;
			// Scores and V finish together on the last grid step
			PROJ_VS: if (wrap) next_phase = FLUSH;
			FLUSH: if (flush_done) next_phase = EMIT;
			EMIT: if (emit_done) next_phase = IDLE;
			default: next_phase = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= IDLE;
		end else begin
			phase <= next_phase;
		end
	end

endmodule

`default_nettype wire

//--- rtl/sa_step_counter.sv
// Grid and emit counters
`default_nettype none

module sa_step_counter
	import sa_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input sa_phase_t phase,
	input tcount_t token_sample,
	output idx_t col,
	output idx_t row,
	output logic wrap,
	output logic flush_done,
	output logic emit_done,
	output tcount_t token_count
);

	logic run;
	logic [2*IDX_W-1:0] step;
	logic [6:0] emit_last;
	emit_t emit_cnt;

	// First input cycle arrives while still in IDLE
	assign run = (phase != IDLE) || in_valid;
	assign step = {row, col};
	assign wrap = (step == (2*IDX_W)'(STEP_CYCLES - 1));
	assign flush_done = (phase == FLUSH) && (col == idx_t'(FLUSH_CYCLES - 1));
	assign emit_last = {token_count, 3'b000} - 7'd1;
	assign emit_done = (phase == EMIT) && ({1'b0, emit_cnt} == emit_last);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
		end else if (!run || emit_done) begin
			col <= '0;
			row <= '0;
		end else begin
			col <= col + 1'b1;
			if (col == idx_t'(DIM - 1)) begin
				row <= row + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			emit_cnt <= '0;
			token_count <= '0;
		end else begin
			if (phase != EMIT || emit_done) begin
				emit_cnt <= '0;
			end else begin
				emit_cnt <= emit_cnt + 1'b1;
			end
			if (phase == IDLE && in_valid) begin
				token_count <= token_sample;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/sa_input_buffer.sv
// Token and weight storage
`default_nettype none

module sa_input_buffer
	import sa_pkg::*;
(
	input logic clk,
	input logic in_valid,
	input sa_phase_t phase,
	input idx_t col,
	input idx_t row,
	input tcount_t token_count,
	input feat_t in_data,
	input feat_t w_q,
	input feat_t w_k,
	input feat_t w_v,
	output feat_t x_col [DIM],
	output feat_t w_elem
);

	feat_t x_mem [DIM][DIM];
	feat_t w_mem [DIM][DIM];
	feat_t w_in;
	logic gather;

	assign gather = (phase == GATHER) && ({1'b0, row} < token_count);

	// Weight stream runs one phase ahead of its projection
	always_comb begin
		case (phase)
			IDLE, GATHER: w_in = w_q;
			PROJ_Q: w_in = w_k;
			default: w_in = w_v;
		endcase
	end

	always_ff @(posedge clk) begin
		if (in_valid && phase == IDLE) begin
			// New job, unused token rows must stay zero
			for (int i = 0; i < DIM; i++) begin
				for (int j = 0; j < DIM; j++) begin
					x_mem[i][j] <= '0;
				end
			end
			x_mem[0][0] <= in_data;
		end else if (gather) begin
			x_mem[row][col] <= in_data;
		end
		if (in_valid) begin
			w_mem[row][col] <= w_in;
		end
	end

	// V is built column by column, so its reads are transposed
	always_comb begin
		if (phase == PROJ_VS) begin
			for (int i = 0; i < DIM; i++) begin
				x_col[i] = x_mem[i][col];
			end
			w_elem = w_mem[col][row];
		end else begin
			for (int i = 0; i < DIM; i++) begin
				x_col[i] = x_mem[i][row];
			end
			w_elem = w_mem[row][col];
		end
	end

endmodule

`default_nettype wire

//--- rtl/sa_projection_unit.sv
// Q, K and V projection lanes
`default_nettype none

module sa_projection_unit
	import sa_pkg::*;
(
	input logic clk,
	input sa_phase_t phase,
	input idx_t col,
	input idx_t row,
	input feat_t x_col [DIM],
	input feat_t w_elem,
	output proj_t q_elem,
	output proj_t k_col [DIM],
	output proj_t v_col [DIM]
);

	proj_t q_mem [DIM][DIM];
	proj_t k_mem [DIM][DIM];
	proj_t v_mem [DIM][DIM];
	proj_t psum [DIM];
	proj_t mac [DIM];

	// One lane per token row
	always_comb begin
		for (int i = 0; i < DIM; i++) begin
			case (phase)
				PROJ_Q: psum[i] = q_mem[i][col];
				PROJ_K: psum[i] = k_mem[i][col];
				default: psum[i] = v_mem[i][row];
			endcase
			mac[i] = psum[i] + x_col[i] * w_elem;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < DIM; i++) begin
			case (phase)
				GATHER: begin
					for (int j = 0; j < DIM; j++) begin
						q_mem[i][j] <= '0;
						k_mem[i][j] <= '0;
						v_mem[i][j] <= '0;
					end
				end
				PROJ_Q: q_mem[i][col] <= mac[i];
				PROJ_K: k_mem[i][col] <= mac[i];
				PROJ_VS: v_mem[i][row] <= mac[i];
				default: ;
			endcase
		end
	end

	assign q_elem = q_mem[row][col];

	always_comb begin
		for (int i = 0; i < DIM; i++) begin
			k_col[i] = k_mem[i][col];
			v_col[i] = v_mem[i][col];
		end
	end

endmodule

`default_nettype wire

//--- rtl/sa_attention_unit.sv
// Score matrix and shared wide multipliers
`default_nettype none

module sa_attention_unit
	import sa_pkg::*;
(
	input logic clk,
	input sa_phase_t phase,
	input idx_t col,
	input idx_t row,
	input proj_t q_elem,
	input proj_t k_col [DIM],
	input proj_t v_col [DIM],
	output prod_t products [DIM]
);

	score_t s_mem [DIM][DIM];
	score_t mult_a [DIM];
	proj_t mult_b [DIM];
	score_t s_next [DIM];
	logic score_phase;

	assign score_phase = (phase == PROJ_VS);

	// Q x K^T while V is built, then S x V for the output
	always_comb begin
		for (int j = 0; j < DIM; j++) begin
			if (score_phase) begin
				mult_a[j] = score_t'(q_elem);
				mult_b[j] = k_col[j];
			end else begin
				mult_a[j] = s_mem[row][j];
				mult_b[j] = v_col[j];
			end
			products[j] = mult_a[j] * mult_b[j];
			s_next[j] = s_mem[row][j] + score_t'(products[j]);
		end
	end

	always_ff @(posedge clk) begin
		if (phase == GATHER) begin
			for (int i = 0; i < DIM; i++) begin
				for (int j = 0; j < DIM; j++) begin
					s_mem[i][j] <= '0;
				end
			end
		end else if (score_phase) begin
			for (int j = 0; j < DIM; j++) begin
				if (col == idx_t'(DIM - 1)) begin
					// Finished score is clipped at zero, then divided by 3
					s_mem[row][j] <= (s_next[j] < 0) ? '0 : s_next[j] / 3;
				end else begin
					s_mem[row][j] <= s_next[j];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/sa_output_tree.sv
// Product and sum pipeline
`default_nettype none

module sa_output_tree
	import sa_pkg::*;
(
	input logic clk,
	input prod_t products [DIM],
	output result_t sum
);

	prod_t p_reg [DIM];
	result_t total;

	always_comb begin
		total = '0;
		for (int j = 0; j < DIM; j++) begin
			total = total + result_t'(p_reg[j]);
		end
	end

	// Two stages, matched by the FLUSH phase
	always_ff @(posedge clk) begin
		for (int j = 0; j < DIM; j++) begin
			p_reg[j] <= products[j];
		end
		sum <= total;
	end

endmodule

`default_nettype wire

//--- rtl/sa_top.sv
// Single-head self-attention engine
`default_nettype none

module sa_top
	import sa_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input tcount_t token_count,
	input feat_t in_data,
	input feat_t w_q,
	input feat_t w_k,
	input feat_t w_v,
	output logic out_valid,
	output result_t out_data
);

	sa_phase_t phase;
	idx_t col;
	idx_t row;
	logic wrap;
	logic flush_done;
	logic emit_done;
	tcount_t job_tokens;
	feat_t x_col [DIM];
	feat_t w_elem;
	proj_t q_elem;
	proj_t k_col [DIM];
	proj_t v_col [DIM];
	prod_t products [DIM];
	result_t sum;

	sa_phase_fsm sa_phase_fsm_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.wrap(wrap),
		.flush_done(flush_done),
		.emit_done(emit_done),
		.phase(phase)
	);

	sa_step_counter sa_step_counter_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.phase(phase),
		.token_sample(token_count),
		.col(col),
		.row(row),
		.wrap(wrap),
		.flush_done(flush_done),
		.emit_done(emit_done),
		.token_count(job_tokens)
	);

	sa_input_buffer sa_input_buffer_inst (
		.clk(clk),
		.in_valid(in_valid),
		.phase(phase),
		.col(col),
		.row(row),
		.token_count(job_tokens),
		.in_data(in_data),
		.w_q(w_q),
		.w_k(w_k),
		.w_v(w_v),
		.x_col(x_col),
		.w_elem(w_elem)
	);

	sa_projection_unit sa_projection_unit_inst (
		.clk(clk),
		.phase(phase),
		.col(col),
		.row(row),
		.x_col(x_col),
		.w_elem(w_elem),
		.q_elem(q_elem),
		.k_col(k_col),
		.v_col(v_col)
	);

	sa_attention_unit sa_attention_unit_inst (
		.clk(clk),
		.phase(phase),
		.col(col),
		.row(row),
		.q_elem(q_elem),
		.k_col(k_col),
		.v_col(v_col),
		.products(products)
	);

	sa_output_tree sa_output_tree_inst (
		.clk(clk),
		.products(products),
		.sum(sum)
	);

	assign out_valid = (phase == EMIT);
	assign out_data = out_valid ? sum : '0;

endmodule

`default_nettype wire

//--- testbench/sa_ref_model.svh
// Attention reference model
`ifndef SA_REF_MODEL_SVH
`define SA_REF_MODEL_SVH

// Job stimulus, indexed [row][col]
int x_ref [DIM][DIM];
int wq_ref [DIM][DIM];
int wk_ref [DIM][DIM];
int wv_ref [DIM][DIM];

// Expected outputs in emit order
longint o_ref [DIM*DIM];

// Raw scores below zero, and positive ones with a remainder after division by 3
int neg_scores;
int odd_scores;

function automatic int pick_value(bit extreme);
	if (extreme) begin
		return ($urandom_range(1) == 1) ? 127 : -128;
	end
	return int'($urandom_range(255)) - 128;
endfunction

function automatic void fill_stimulus(bit extreme);
	for (int i = 0; i < DIM; i++) begin
		for (int j = 0; j < DIM; j++) begin
			x_ref[i][j] = pick_value(extreme);
			wq_ref[i][j] = pick_value(extreme);
			wk_ref[i][j] = pick_value(extreme);
			wv_ref[i][j] = pick_value(extreme);
		end
	end
endfunction

function automatic void compute_reference(int tokens);
	longint q [DIM][DIM];
	longint k [DIM][DIM];
	longint v [DIM][DIM];
	longint s [DIM][DIM];
	longint acc;
	longint xv;
	neg_scores = 0;
	odd_scores = 0;
	// Token rows past the count are zero
	for (int i = 0; i < DIM; i++) begin
		for (int j = 0; j < DIM; j++) begin
			q[i][j] = 0;
			k[i][j] = 0;
			v[i][j] = 0;
			for (int r = 0; r < DIM; r++) begin
				xv = (i < tokens) ? longint'(x_ref[i][r]) : 0;
				q[i][j] += xv * wq_ref[r][j];
				k[i][j] += xv * wk_ref[r][j];
				v[i][j] += xv * wv_ref[r][j];
			end
		end
	end
	for (int i = 0; i < DIM; i++) begin
		for (int j = 0; j < DIM; j++) begin
			acc = 0;
			for (int c = 0; c < DIM; c++) begin
				acc += q[i][c] * k[j][c];
			end
			if (acc < 0) begin
				s[i][j] = 0;
				neg_scores++;
			end else begin
				s[i][j] = acc / 3;
				if (acc % 3 != 0) begin
					odd_scores++;
				end
			end
		end
	end
	for (int i = 0; i < DIM; i++) begin
		for (int c = 0; c < DIM; c++) begin
			acc = 0;
			for (int j = 0; j < DIM; j++) begin
				acc += s[i][j] * v[j][c];
			end
			o_ref[i*DIM + c] = acc;
		end
	end
endfunction

`endif

//--- testbench/tb_sa_top.sv
// Self-attention engine testbench
`default_nettype none

module tb_sa_top
	import sa_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LATENCY = 67;
	localparam int NUM_JOBS = 6;
	localparam int JOB_CYCLES = 400;
	localparam int GAP_LIMIT = 1000;

	logic clk = 1'b0;
	logic rst_n;
	logic in_valid;
	tcount_t token_count;
	feat_t in_data;
	feat_t w_q;
	feat_t w_k;
	feat_t w_v;
	logic out_valid;
	result_t out_data;

	// Cycles since the last input cycle, saturating
	int gap = GAP_LIMIT;
	int exp_len = 0;
	logic exp_valid;
	result_t exp_data;

	`include "sa_ref_model.svh"

	sa_top sa_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.token_count(token_count),
		.in_data(in_data),
		.w_q(w_q),
		.w_k(w_k),
		.w_v(w_v),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		if (in_valid) begin
			gap <= 1;
		end else if (gap < GAP_LIMIT) begin
			gap <= gap + 1;
		end
	end

	// A new job may start in the cycle right after the previous emit
	assign exp_valid = !in_valid && (gap >= LATENCY) && (gap < LATENCY + exp_len);
	assign exp_data = exp_valid ? result_t'(o_ref[gap - LATENCY]) : '0;

	task automatic fail_run(string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	valid_window: assert property (@(posedge clk) disable iff (!rst_n) out_valid == exp_valid)
		else fail_run($sformatf("error: out_valid = 0x%h expected 0x%h",
			$sampled(out_valid), $sampled(exp_valid)));

	data_match: assert property (@(posedge clk) exp_valid |-> out_data == exp_data)
		else fail_run($sformatf("error: out_data = 0x%h expected 0x%h",
			$sampled(out_data), $sampled(exp_data)));

	idle_zero: assert property (@(posedge clk) !out_valid |-> out_data == '0)
		else fail_run($sformatf("error: out_data = 0x%h expected 0x%h",
			$sampled(out_data), 64'h0));

	// Model is updated right after an edge, so the previous emit is already sampled
	task automatic run_job(int tokens, bit extreme);
		int r;
		int k;
		@(posedge clk);
		fill_stimulus(extreme);
		compute_reference(tokens);
		exp_len = tokens * DIM;
		for (int c = 0; c < 3 * STEP_CYCLES; c++) begin
			r = (c % STEP_CYCLES) / DIM;
			k = c % DIM;
			in_valid <= 1'b1;
			token_count <= (c == 0) ? tcount_t'(tokens) : tcount_t'($urandom);
			in_data <= (c < STEP_CYCLES) ? feat_t'(x_ref[r][k]) : feat_t'($urandom);
			w_q <= (c < STEP_CYCLES) ? feat_t'(wq_ref[r][k]) : feat_t'($urandom);
			w_k <= (c / STEP_CYCLES == 1) ? feat_t'(wk_ref[r][k]) : feat_t'($urandom);
			w_v <= (c / STEP_CYCLES == 2) ? feat_t'(wv_ref[r][k]) : feat_t'($urandom);
			@(posedge clk);
		end
		in_valid <= 1'b0;
	endtask

	// Returns during the last emit cycle
	task automatic wait_for_emit(int tokens);
		int seen;
		seen = 0;
		while (seen < tokens * DIM) begin
			@(negedge clk);
			if (out_valid) begin
				seen++;
			end
		end
	endtask

	initial begin
		#(NUM_JOBS * JOB_CYCLES * 8);
		fail_run("timeout: the jobs did not finish in time");
	end

	initial begin
		void'($urandom(89));
		rst_n = 1'b0;
		in_valid = 1'b0;
		token_count = '0;
		in_data = '0;
		w_q = '0;
		w_k = '0;
		w_v = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);
		run_job(8, 1'b0);
		wait_for_emit(8);
		run_job(1, 1'b0);
		wait_for_emit(1);
		run_job(4, 1'b0);
		wait_for_emit(4);
		run_job(5, 1'b0);
		if (neg_scores == 0 || odd_scores == 0) begin
			fail_run("rectify job lacks a negative score or a score with a remainder");
		end
		wait_for_emit(5);
		// Extreme job, then a short one straight after it
		run_job(8, 1'b1);
		wait_for_emit(8);
		run_job(2, 1'b0);
		wait_for_emit(2);
		repeat (4) @(posedge clk);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+testbench
rtl/sa_pkg.sv
rtl/sa_phase_fsm.sv
rtl/sa_step_counter.sv
rtl/sa_input_buffer.sv
rtl/sa_projection_unit.sv
rtl/sa_attention_unit.sv
rtl/sa_output_tree.sv
rtl/sa_top.sv
testbench/tb_sa_top.sv

//--- Makefile
TOP = tb_sa_top

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -qx 'PASS: all tests' sim.log

obj_dir/V$(TOP): filelist.f rtl/*.sv testbench/*.sv testbench/*.svh
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
